// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = accel_tile_tb
FILELIST  = all.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

// ==== all.f ====
+incdir+include
source/accel_pkg.sv
source/accel_link_if.sv
source/accel_endpoint.sv
source/accel_core.sv
source/accel_tile.sv
tb/accel_tile_tb.sv

// ==== include/accel_params.svh ====
`ifndef ACCEL_PARAMS_SVH
`define ACCEL_PARAMS_SVH

// data word carried by a remote store
`define ACCEL_DATA_W 32

// word address of an outgoing packet
`define ACCEL_ADDR_W 16

// mesh coordinate widths
`define ACCEL_X_W 4
`define ACCEL_Y_W 4

// low address bits of an incoming request that the core decodes
`define ACCEL_REQ_ADDR_W 2

// op code and byte enable widths of a packet
`define ACCEL_OP_W 2
`define ACCEL_MASK_W 4

// request FIFO, depth and pointer width
`define ACCEL_FIFO_ELS 4
`define ACCEL_FIFO_PTR_W 2

// outgoing credits after reset and the counter width that holds them
`define ACCEL_CREDITS 4
`define ACCEL_CREDIT_W 3

`endif

// ==== source/accel_core.sv ====
`timescale 1ns/1ps

`include "accel_params.svh"

module accel_core
(
   input  logic                  clk_i,
   input  logic                  arst_n_i,

   // own coordinate, used as return address
   input  logic [`ACCEL_X_W-1:0] my_x_i,
   input  logic [`ACCEL_Y_W-1:0] my_y_i,

   accel_link_if.core            link_if
);

   localparam int unsigned NUM_EN   = 1 << `ACCEL_REQ_ADDR_W;
   localparam int unsigned ADDR_TAG = 0;
   localparam int unsigned ADDR_DST = 1;
   localparam int unsigned ADDR_FWD = 2;
   localparam int unsigned ADDR_NOP = 3;

   logic [NUM_EN-1:0]            addr_en;
   accel_pkg::accel_cfg_word_u   cfg_word;

   logic [`ACCEL_ADDR_W-1:0]     tag_r;
   logic [`ACCEL_X_W-1:0]        dest_x_r;
   logic [`ACCEL_Y_W-1:0]        dest_y_r;

   logic                         fwd_v;

   // one-hot decode of the head address, qualified by valid
   always_comb
   begin
      addr_en = '0;
      if (link_if.req_v)
         addr_en[link_if.req_addr] = 1'b1;
   end

   assign cfg_word = link_if.req_data;

   // address 0, tag for outgoing packets
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         tag_r <= '0;
      else if (addr_en[ADDR_TAG])
         tag_r <= cfg_word.addr.tag;
   end

   // address 1, destination y,x
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         dest_x_r <= '0;
         dest_y_r <= '0;
      end
      else if (addr_en[ADDR_DST])
      begin
         dest_x_r <= cfg_word.dest.x;
         dest_y_r <= cfg_word.dest.y;
      end
   end

   // address 2, forward only while a credit is held
   assign fwd_v        = addr_en[ADDR_FWD] && link_if.pkt_credit_avail;
   assign link_if.pkt_v = fwd_v;

   // address 3 is eaten so a stray store cannot stall the queue
   assign link_if.req_yumi = addr_en[ADDR_TAG] | addr_en[ADDR_DST] | fwd_v
                             | addr_en[ADDR_NOP];

   // packet assembly
   always_comb
   begin
      link_if.pkt.addr   = tag_r;
      link_if.pkt.data   = link_if.req_data;
      link_if.pkt.op     = accel_pkg::ACCEL_OP_STORE;
      // full word write
      link_if.pkt.op_ex  = '1;
      link_if.pkt.dest_x = dest_x_r;
      link_if.pkt.dest_y = dest_y_r;
      link_if.pkt.src_x  = my_x_i;
      link_if.pkt.src_y  = my_y_i;
   end

   a_yumi_needs_v: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      link_if.req_yumi |-> link_if.req_v);

endmodule

// ==== source/accel_endpoint.sv ====
`timescale 1ns/1ps

`include "accel_params.svh"

module accel_endpoint
(
   input  logic                         clk_i,
   input  logic                         arst_n_i,

   // requests from the network
   input  logic                         req_v_i,
   input  logic [`ACCEL_REQ_ADDR_W-1:0] req_addr_i,
   input  logic [`ACCEL_DATA_W-1:0]     req_data_i,
   output logic                         req_ready_o,

   // packets towards the network
   output logic                         out_v_o,
   output accel_pkg::accel_packet_s     out_pkt_o,
   input  logic                         credit_return_i,

   accel_link_if.endpoint               link_if
);

   logic [`ACCEL_REQ_ADDR_W-1:0] addr_mem [`ACCEL_FIFO_ELS];
   logic [`ACCEL_DATA_W-1:0]     data_mem [`ACCEL_FIFO_ELS];

   logic [`ACCEL_FIFO_PTR_W-1:0] wr_ptr;
   logic [`ACCEL_FIFO_PTR_W-1:0] rd_ptr;
   logic [`ACCEL_FIFO_PTR_W:0]   count;
   logic                         full;
   logic                         push;
   logic                         pop;

   logic [`ACCEL_CREDIT_W-1:0]   credit_cnt;
   logic                         out_v_r;
   accel_pkg::accel_packet_s     out_pkt_r;

   assign full        = (count == (`ACCEL_FIFO_PTR_W+1)'(`ACCEL_FIFO_ELS));
   assign req_ready_o = !full;
   assign push        = req_v_i && req_ready_o;
   assign pop         = link_if.req_yumi;

   // storage, written on accept only
   always_ff @(posedge clk_i)
   begin
      if (push)
      begin
         addr_mem[wr_ptr] <= req_addr_i;
         data_mem[wr_ptr] <= req_data_i;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= (wr_ptr == `ACCEL_FIFO_PTR_W'(`ACCEL_FIFO_ELS - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == `ACCEL_FIFO_PTR_W'(`ACCEL_FIFO_ELS - 1)) ? '0 : rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // head of queue goes straight to the core
   assign link_if.req_v    = (count != '0);
   assign link_if.req_addr = addr_mem[rd_ptr];
   assign link_if.req_data = data_mem[rd_ptr];

   // credit counter, a send and a return may land together
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         credit_cnt <= `ACCEL_CREDIT_W'(`ACCEL_CREDITS);
      else
      begin
         case ({link_if.pkt_v, credit_return_i})
            2'b10:   credit_cnt <= credit_cnt - 1'b1;
            2'b01:   credit_cnt <= credit_cnt + 1'b1;
            default: credit_cnt <= credit_cnt;
         endcase
      end
   end

   assign link_if.pkt_credit_avail = (credit_cnt != '0);

   // outgoing packet held for one cycle
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         out_v_r <= 1'b0;
      else
         out_v_r <= link_if.pkt_v;
   end

   always_ff @(posedge clk_i)
   begin
      if (link_if.pkt_v)
         out_pkt_r <= link_if.pkt;
   end

   assign out_v_o   = out_v_r;
   assign out_pkt_o = out_pkt_r;

   // a push into a full ring would land on the unread head
   a_no_push_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      push |-> (wr_ptr != rd_ptr) || (count == '0));

   a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      !link_if.req_v |-> !pop);

   // stray credit returns from the network would overflow this
   a_credit_max: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      credit_cnt <= `ACCEL_CREDIT_W'(`ACCEL_CREDITS));

   a_no_send_zero: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      link_if.pkt_v |-> credit_cnt != '0);

endmodule

// ==== source/accel_link_if.sv ====
`timescale 1ns/1ps

`include "accel_params.svh"

interface accel_link_if;

   // request channel, head of the endpoint FIFO
   logic                             req_v;
   logic [`ACCEL_REQ_ADDR_W-1:0]     req_addr;
   logic [`ACCEL_DATA_W-1:0]         req_data;
   logic                             req_yumi;

   // packet channel towards the network
   accel_pkg::accel_packet_s         pkt;
   logic                             pkt_v;
   logic                             pkt_credit_avail;

   modport endpoint
   (
      output req_v,
      output req_addr,
      output req_data,
      input  req_yumi,
      input  pkt,
      input  pkt_v,
      output pkt_credit_avail
   );

   modport core
   (
      input  req_v,
      input  req_addr,
      input  req_data,
      output req_yumi,
      output pkt,
      output pkt_v,
      input  pkt_credit_avail
   );

endinterface

// ==== source/accel_pkg.sv ====
`include "accel_params.svh"

package accel_pkg;

   // network op codes, the tile only ever emits store
   typedef enum logic [`ACCEL_OP_W-1:0]
   {
      ACCEL_OP_LOAD   = 2'd0,
      ACCEL_OP_STORE  = 2'd1,
      ACCEL_OP_UNUSED = 2'd2
   } accel_op_e;

   // outgoing remote store packet
   typedef struct packed
   {
      logic [`ACCEL_ADDR_W-1:0] addr;
      logic [`ACCEL_DATA_W-1:0] data;
      accel_op_e                op;
      logic [`ACCEL_MASK_W-1:0] op_ex;
      logic [`ACCEL_X_W-1:0]    dest_x;
      logic [`ACCEL_Y_W-1:0]    dest_y;
      // return address of the sending tile
      logic [`ACCEL_X_W-1:0]    src_x;
      logic [`ACCEL_Y_W-1:0]    src_y;
   } accel_packet_s;

   // address tag view, tag in the low bits
   typedef struct packed
   {
      logic [`ACCEL_DATA_W-`ACCEL_ADDR_W-1:0] pad;
      logic [`ACCEL_ADDR_W-1:0]               tag;
   } accel_cfg_addr_s;

   // destination view, y sits above x
   typedef struct packed
   {
      logic [`ACCEL_DATA_W-`ACCEL_Y_W-`ACCEL_X_W-1:0] pad;
      logic [`ACCEL_Y_W-1:0]                          y;
      logic [`ACCEL_X_W-1:0]                          x;
   } accel_cfg_dest_s;

   // one configuration write, decoded by its target address
   typedef union packed
   {
      accel_cfg_addr_s addr;
      accel_cfg_dest_s dest;
   } accel_cfg_word_u;

endpackage

// ==== source/accel_tile.sv ====
`timescale 1ns/1ps

`include "accel_params.svh"

module accel_tile
(
   input  logic                         clk_i,
   input  logic                         arst_n_i,

   input  logic [`ACCEL_X_W-1:0]        my_x_i,
   input  logic [`ACCEL_Y_W-1:0]        my_y_i,

   // remote store requests
   input  logic                         req_v_i,
   input  logic [`ACCEL_REQ_ADDR_W-1:0] req_addr_i,
   input  logic [`ACCEL_DATA_W-1:0]     req_data_i,
   output logic                         req_ready_o,

   // outgoing packet, split into fields
   output logic                         out_v_o,
   output logic [`ACCEL_ADDR_W-1:0]     out_addr_o,
   output logic [`ACCEL_DATA_W-1:0]     out_data_o,
   output logic [`ACCEL_OP_W-1:0]       out_op_o,
   output logic [`ACCEL_MASK_W-1:0]     out_op_ex_o,
   output logic [`ACCEL_X_W-1:0]        out_dest_x_o,
   output logic [`ACCEL_Y_W-1:0]        out_dest_y_o,
   output logic [`ACCEL_X_W-1:0]        out_src_x_o,
   output logic [`ACCEL_Y_W-1:0]        out_src_y_o,

   input  logic                         credit_return_i
);

   accel_pkg::accel_packet_s out_pkt;

   accel_link_if link_if ();

   accel_endpoint endpoint_i
   (
      .clk_i           (clk_i),
      .arst_n_i        (arst_n_i),
      .req_v_i         (req_v_i),
      .req_addr_i      (req_addr_i),
      .req_data_i      (req_data_i),
      .req_ready_o     (req_ready_o),
      .out_v_o         (out_v_o),
      .out_pkt_o       (out_pkt),
      .credit_return_i (credit_return_i),
      .link_if         (link_if.endpoint)
   );

   accel_core core_i
   (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .my_x_i   (my_x_i),
      .my_y_i   (my_y_i),
      .link_if  (link_if.core)
   );

   assign out_addr_o   = out_pkt.addr;
   assign out_data_o   = out_pkt.data;
   assign out_op_o     = out_pkt.op;
   assign out_op_ex_o  = out_pkt.op_ex;
   assign out_dest_x_o = out_pkt.dest_x;
   assign out_dest_y_o = out_pkt.dest_y;
   assign out_src_x_o  = out_pkt.src_x;
   assign out_src_y_o  = out_pkt.src_y;

endmodule

// ==== tb/accel_tile_tb.sv ====
`timescale 1ns/1ps

`include "accel_params.svh"

module accel_tile_tb;

   localparam int CLK_NS   = 20;
   localparam int DRIVE_NS = 2;
   localparam int N_STREAM = 12;
   // per-test cycle budgets: defaults, config, credits, redirect, stream, unmapped
   localparam int BUDGET      = 40 + 40 + 100 + 40 + 150 + 40;
   localparam int WATCHDOG_NS = (8 + BUDGET + 100) * CLK_NS;

   logic clk_i;
   logic arst_n_i;
   logic [`ACCEL_X_W-1:0] my_x_i;
   logic [`ACCEL_Y_W-1:0] my_y_i;
   logic req_v_i;
   logic [`ACCEL_REQ_ADDR_W-1:0] req_addr_i;
   logic [`ACCEL_DATA_W-1:0] req_data_i;
   logic req_ready_o;
   logic out_v_o;
   logic [`ACCEL_ADDR_W-1:0] out_addr_o;
   logic [`ACCEL_DATA_W-1:0] out_data_o;
   logic [`ACCEL_OP_W-1:0] out_op_o;
   logic [`ACCEL_MASK_W-1:0] out_op_ex_o;
   logic [`ACCEL_X_W-1:0] out_dest_x_o;
   logic [`ACCEL_Y_W-1:0] out_dest_y_o;
   logic [`ACCEL_X_W-1:0] out_src_x_o;
   logic [`ACCEL_Y_W-1:0] out_src_y_o;
   logic credit_return_i;

   accel_pkg::accel_packet_s pkt_q[$];
   accel_pkg::accel_packet_s exp_q[$];
   logic [31:0] lcg_state;
   logic [`ACCEL_ADDR_W-1:0] exp_tag;
   logic [`ACCEL_X_W-1:0] exp_dx;
   logic [`ACCEL_Y_W-1:0] exp_dy;
   int errors;
   int err_at_start;
   int tests_run;
   int tests_failed;

   accel_tile dut_i
   (
      .clk_i (clk_i), .arst_n_i (arst_n_i), .my_x_i (my_x_i), .my_y_i (my_y_i),
      .req_v_i (req_v_i), .req_addr_i (req_addr_i), .req_data_i (req_data_i),
      .req_ready_o (req_ready_o), .out_v_o (out_v_o), .out_addr_o (out_addr_o),
      .out_data_o (out_data_o), .out_op_o (out_op_o), .out_op_ex_o (out_op_ex_o),
      .out_dest_x_o (out_dest_x_o), .out_dest_y_o (out_dest_y_o),
      .out_src_x_o (out_src_x_o), .out_src_y_o (out_src_y_o),
      .credit_return_i (credit_return_i)
   );

   initial
   begin
      clk_i = 1'b0;
      forever #(CLK_NS / 2) clk_i = ~clk_i;
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("watchdog expired before the tests completed");
      $display("*** TEST FAILED ***");
      $finish;
   end

   // collect every packet the tile sends, mid-cycle
   always @(negedge clk_i)
   begin
      accel_pkg::accel_packet_s p;
      if (arst_n_i && out_v_o)
      begin
         p = '{addr: out_addr_o, data: out_data_o, op: accel_pkg::accel_op_e'(out_op_o),
               op_ex: out_op_ex_o, dest_x: out_dest_x_o, dest_y: out_dest_y_o,
               src_x: out_src_x_o, src_y: out_src_y_o};
         pkt_q.push_back(p);
      end
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // full-word store from this tile, with the current tag and destination
   function automatic accel_pkg::accel_packet_s expect_pkt(input logic [31:0] data);
      return '{addr: exp_tag, data: data, op: accel_pkg::ACCEL_OP_STORE, op_ex: 4'hf,
               dest_x: exp_dx, dest_y: exp_dy, src_x: my_x_i, src_y: my_y_i};
   endfunction

   task automatic check_pkt(input string name, input accel_pkg::accel_packet_s exp,
                            input accel_pkg::accel_packet_s act);
      if (act !== exp)
      begin
         errors++;
         $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
      begin
         errors++;
         $display("Mismatch in %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic check_count(input string name, input logic [`ACCEL_CREDIT_W-1:0] exp,
                              input logic [`ACCEL_CREDIT_W-1:0] act);
      if (act !== exp)
      begin
         errors++;
         $display("Mismatch in %s: expected %0d, actual %0d", name, exp, act);
      end
   endtask

   task automatic check_len(input string name, input int exp, input int act);
      if (act != exp)
      begin
         errors++;
         $display("Mismatch in %s: expected %0d packets, actual %0d", name, exp, act);
      end
   endtask

   task automatic idle(input int n);
      repeat (n)
      begin
         @(posedge clk_i);
         #DRIVE_NS;
      end
   endtask

   // hold the word until an edge where the FIFO has room
   task automatic push_word(input logic [`ACCEL_REQ_ADDR_W-1:0] addr, input logic [31:0] data);
      logic rdy;
      req_v_i    = 1'b1;
      req_addr_i = addr;
      req_data_i = data;
      do
      begin
         @(negedge clk_i);
         rdy = req_ready_o;
         @(posedge clk_i);
         #DRIVE_NS;
      end while (!rdy);
      req_v_i = 1'b0;
   endtask

   task automatic write_tag(input logic [`ACCEL_ADDR_W-1:0] tag);
      logic [31:0] junk;
      junk    = lcg_next();
      exp_tag = tag;
      push_word(2'd0, {junk[31:16], tag});
   endtask

   task automatic write_dest(input logic [`ACCEL_Y_W-1:0] y, input logic [`ACCEL_X_W-1:0] x);
      logic [31:0] junk;
      junk   = lcg_next();
      exp_dx = x;
      exp_dy = y;
      push_word(2'd1, {junk[31:8], y, x});
   endtask

   task automatic forward(input logic [31:0] data);
      exp_q.push_back(expect_pkt(data));
      push_word(2'd2, data);
   endtask

   task automatic return_credits(input int n);
      repeat (n)
      begin
         credit_return_i = 1'b1;
         @(posedge clk_i);
         #DRIVE_NS;
      end
      credit_return_i = 1'b0;
   endtask

   task automatic sample_outputs(input string name, input logic exp_ready, input logic exp_v);
      @(negedge clk_i);
      check_bit({name, " req_ready_o"}, exp_ready, req_ready_o);
      check_bit({name, " out_v_o"}, exp_v, out_v_o);
      @(posedge clk_i);
      #DRIVE_NS;
   endtask

   task automatic wait_packets(input string name, input int n);
      int k;
      k = 0;
      while (pkt_q.size() < n && k < 60)
      begin
         @(posedge clk_i);
         #DRIVE_NS;
         k++;
      end
      if (pkt_q.size() < n)
      begin
         errors++;
         $display("%s: only %0d of %0d packets arrived", name, pkt_q.size(), n);
      end
   endtask

   task automatic compare_all(input string name);
      check_len(name, exp_q.size(), pkt_q.size());
      for (int i = 0; i < exp_q.size() && i < pkt_q.size(); i++)
         check_pkt($sformatf("%s packet %0d", name, i), exp_q[i], pkt_q[i]);
   endtask

   task automatic start_test();
      err_at_start = errors;
      pkt_q.delete();
      exp_q.delete();
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (errors > err_at_start)
      begin
         tests_failed++;
         $display("%s: failed with %0d errors", name, errors - err_at_start);
      end
      else
         $display("%s: ok", name);
   endtask

   task automatic test_reset_defaults();
      start_test();
      sample_outputs("reset_defaults", 1'b1, 1'b0);
      // no tag or destination written yet
      forward(lcg_next());
      wait_packets("reset_defaults", 1);
      idle(3);
      compare_all("reset_defaults");
      return_credits(1);
      end_test("reset_defaults");
   endtask

   task automatic test_config_forward();
      start_test();
      write_tag(16'h5a3c);
      write_dest(4'h6, 4'h2);
      idle(3);
      forward(lcg_next());
      // accepted on the last edge, out_v_o expected in the second cycle after
      @(negedge clk_i);
      check_bit("config_forward cycle 1 out_v_o", 1'b0, out_v_o);
      @(negedge clk_i);
      check_bit("config_forward cycle 2 out_v_o", 1'b1, out_v_o);
      @(posedge clk_i);
      #DRIVE_NS;
      wait_packets("config_forward", 1);
      idle(3);
      compare_all("config_forward");
      return_credits(1);
      end_test("config_forward");
   endtask

   task automatic test_credit_limit();
      start_test();
      repeat (6)
         forward(lcg_next());
      wait_packets("credit_limit", `ACCEL_CREDITS);
      idle(4);
      check_count("credit_limit sent", `ACCEL_CREDIT_W'(`ACCEL_CREDITS),
                  `ACCEL_CREDIT_W'(pkt_q.size()));
      sample_outputs("credit_limit two queued", 1'b1, 1'b0);
      // same destination again, only to fill the FIFO behind the stalled words
      write_dest(exp_dy, exp_dx);
      write_dest(exp_dy, exp_dx);
      sample_outputs("credit_limit full", 1'b0, 1'b0);
      return_credits(2);
      wait_packets("credit_limit", 6);
      idle(4);
      sample_outputs("credit_limit drained", 1'b1, 1'b0);
      compare_all("credit_limit");
      return_credits(4);
      end_test("credit_limit");
   endtask

   task automatic test_redirect();
      start_test();
      write_dest(4'h1, 4'h7);
      forward(lcg_next());
      write_dest(4'hc, 4'h9);
      forward(lcg_next());
      wait_packets("redirect", 2);
      idle(3);
      compare_all("redirect");
      return_credits(2);
      end_test("redirect");
   endtask

   task automatic test_stream();
      start_test();
      fork
         begin
            repeat (N_STREAM)
               forward(lcg_next());
         end
         begin
            int returned;
            logic seen;
            returned = 0;
            // hand back one credit for each packet seen
            while (returned < N_STREAM)
            begin
               @(negedge clk_i);
               seen = out_v_o;
               @(posedge clk_i);
               #DRIVE_NS;
               credit_return_i = seen;
               if (seen)
                  returned++;
            end
            idle(1);
            credit_return_i = 1'b0;
         end
      join
      wait_packets("stream", N_STREAM);
      idle(3);
      compare_all("stream");
      end_test("stream");
   endtask

   task automatic test_unmapped();
      start_test();
      push_word(2'd3, lcg_next());
      forward(lcg_next());
      wait_packets("unmapped", 1);
      idle(4);
      compare_all("unmapped");
      return_credits(1);
      end_test("unmapped");
   endtask

   initial
   begin
      arst_n_i        = 1'b0;
      my_x_i          = 4'h3;
      my_y_i          = 4'h5;
      req_v_i         = 1'b0;
      req_addr_i      = '0;
      req_data_i      = '0;
      credit_return_i = 1'b0;
      lcg_state       = 32'hb257f06c;
      exp_tag         = '0;
      exp_dx          = '0;
      exp_dy          = '0;
      errors          = 0;
      tests_run       = 0;
      tests_failed    = 0;
      repeat (8) @(posedge clk_i);
      #DRIVE_NS;
      arst_n_i = 1'b1;
      idle(2);
      test_reset_defaults();
      test_config_forward();
      test_credit_limit();
      test_redirect();
      test_stream();
      test_unmapped();
      $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0 && tests_failed == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule
